// File: source/z8Pkg.sv
package z8Pkg;

    localparam logic [15:0] RESET_PC = 16'h000C;
    localparam int REG_COUNT = 128;
    localparam logic [7:0] FLAGS_ADDR = 8'hFC;
    localparam logic [7:0] RP_ADDR = 8'hFD;
    localparam logic [3:0] WORKING_PREFIX = 4'hE;

    typedef struct packed {
        logic       c;
        logic       z;
        logic       s;
        logic       v;
        logic [3:0] unused;
    } flagsT;

    // One-operand codes use the opcode high nibble, two-operand codes add a leading 1
    typedef enum logic [4:0] {
        ALU_DEC = 5'h00,
        ALU_INC = 5'h02,
        ALU_COM = 5'h06,
        ALU_CLR = 5'h0B,
        ALU_LD  = 5'h0F,
        ALU_ADD = 5'h10,
        ALU_ADC = 5'h11,
        ALU_SUB = 5'h12,
        ALU_SBC = 5'h13,
        ALU_OR  = 5'h14,
        ALU_AND = 5'h15,
        ALU_CP  = 5'h1A,
        ALU_XOR = 5'h1B
    } aluOpT;

    typedef enum logic [3:0] {
        FETCH1,
        READ1,
        FETCH2,
        READ2,
        FETCH3,
        READ3,
        EXECUTE,
        LDC_ADDR,
        WRITE_MEM
    } stateT;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dataWrite;
        logic        write;
        logic        strobe;
    } memBusT;

    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data;
        logic       enable;
    } regWriteT;

    typedef enum logic [1:0] {
        PC_HOLD,
        PC_INC,
        PC_REL,
        PC_ABS
    } pcCmdT;

endpackage

// File: source/alu.sv
`timescale 1ns/1ps

module alu
    import z8Pkg::*;
(
    input  aluOpT      aluOp,
    input  logic [7:0] a,
    input  logic [7:0] b,
    input  flagsT      flagsIn,
    output logic [7:0] result,
    output flagsT      newFlags
);
    logic [8:0] wide;
    logic       carryIn;
    logic       updateZs;

    always_comb begin
        wide = 9'h000;
        carryIn = 1'b0;
        result = a;
        newFlags = flagsIn;
        updateZs = 1'b1;
        case (aluOp)
            ALU_ADD, ALU_ADC: begin
                carryIn = (aluOp == ALU_ADC) & flagsIn.c;
                wide = {1'b0, a} + {1'b0, b} + {8'h00, carryIn};
                result = wide[7:0];
                newFlags.c = wide[8];
                newFlags.v = (a[7] == b[7]) && (result[7] != a[7]);
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                // Carry holds the borrow
                carryIn = (aluOp == ALU_SBC) & flagsIn.c;
                wide = {1'b0, a} - {1'b0, b} - {8'h00, carryIn};
                result = wide[7:0];
                newFlags.c = wide[8];
                newFlags.v = (a[7] != b[7]) && (result[7] != a[7]);
            end
            ALU_OR: begin
                result = a | b;
                newFlags.v = 1'b0;
            end
            ALU_AND: begin
                result = a & b;
                newFlags.v = 1'b0;
            end
            ALU_XOR: begin
                result = a ^ b;
                newFlags.v = 1'b0;
            end
            ALU_DEC: begin
                result = a - 8'd1;
                newFlags.v = (a == 8'h80);
            end
            ALU_INC: begin
                result = a + 8'd1;
                newFlags.v = (a == 8'h7F);
            end
            ALU_COM: begin
                result = ~a;
                newFlags.v = 1'b0;
            end
            ALU_CLR: begin
                result = 8'h00;
                updateZs = 1'b0;
            end
            default: updateZs = 1'b0;
        endcase
        if (updateZs) begin
            newFlags.z = (result == 8'h00);
            newFlags.s = result[7];
        end
    end
endmodule

// File: source/registerFile.sv
`timescale 1ns/1ps

module registerFile
    import z8Pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic [7:0] readAddrA,
    input  logic [7:0] readAddrB,
    input  regWriteT   regWrite,
    input  logic       flagsWrite,
    input  flagsT      flagsData,
    output logic [7:0] readA,
    output logic [7:0] readB,
    output flagsT      flags,
    output logic [3:0] rp
);
    logic [7:0] regs [REG_COUNT];

    function automatic logic [7:0] readReg(input logic [7:0] addr);
        if (!addr[7]) return regs[addr[6:0]];
        if (addr == FLAGS_ADDR) return flags;
        if (addr == RP_ADDR) return {rp, 4'h0};
        return 8'h00;
    endfunction

    always_comb begin
        readA = readReg(readAddrA);
        readB = readReg(readAddrB);
    end

    always_ff @(posedge clk) begin
        if (regWrite.enable && !regWrite.addr[7]) begin
            regs[regWrite.addr[6:0]] <= regWrite.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            flags <= '0;
            rp <= 4'h0;
        end else begin
            // Direct write to FC wins over the ALU flags
            if (regWrite.enable && regWrite.addr == FLAGS_ADDR) begin
                flags <= flagsT'(regWrite.data);
            end else if (flagsWrite) begin
                flags <= flagsData;
            end
            if (regWrite.enable && regWrite.addr == RP_ADDR) begin
                rp <= regWrite.data[7:4];
            end
        end
    end
endmodule

// File: source/programCounter.sv
`timescale 1ns/1ps

module programCounter
    import z8Pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  pcCmdT       pcCmd,
    input  logic [15:0] jumpTarget,
    output logic [15:0] pc
);
    logic [15:0] displacement;

    // Relative jumps count from the next instruction
    assign displacement = {{8{jumpTarget[7]}}, jumpTarget[7:0]};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= RESET_PC;
        end else begin
            case (pcCmd)
                PC_INC:  pc <= pc + 16'd1;
                PC_REL:  pc <= pc + displacement;
                PC_ABS:  pc <= jumpTarget;
                default: pc <= pc;
            endcase
        end
    end

    // First fetch out of reset starts at RESET_PC and steps past it
    assert property (@(posedge clk) $rose(rstN) |=>
        $past(pc) == RESET_PC && pc == RESET_PC + 16'd1);
endmodule

// File: source/controlFsm.sv
`timescale 1ns/1ps

module controlFsm
    import z8Pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic [7:0]  memDataRead,
    input  logic [15:0] pc,
    input  logic [7:0]  readA,
    input  logic [7:0]  readB,
    input  flagsT       flags,
    input  logic [3:0]  rp,
    input  logic [7:0]  aluResult,
    input  flagsT       newFlags,
    output memBusT      bus,
    output pcCmdT       pcCmd,
    output logic [15:0] jumpTarget,
    output logic [7:0]  readAddrA,
    output logic [7:0]  readAddrB,
    output aluOpT       aluOp,
    output logic [7:0]  aluA,
    output logic [7:0]  aluB,
    output regWriteT    regWrite,
    output logic        flagsWrite,
    output flagsT       flagsData
);
    stateT       state;
    stateT       nextState;
    logic [7:0]  opcode;
    logic [7:0]  second;
    logic [7:0]  third;
    logic [15:0] ldcAddr;
    logic        condLow;
    logic        takeBranch;

    wire [3:0] instrH = opcode[7:4];
    wire [3:0] instrL = opcode[3:0];
    wire [3:0] secondH = second[7:4];
    wire [3:0] secondL = second[3:0];

    function automatic logic [7:0] workReg(input logic [3:0] r);
        return {rp, r};
    endfunction

    // Working registers E0-EF map through the pointer
    function automatic logic [7:0] resolve(input logic [7:0] r);
        return (r[7:4] == WORKING_PREFIX) ? workReg(r[3:0]) : r;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= FETCH1;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == READ1) opcode <= memDataRead;
        if (state == READ2) second <= memDataRead;
        if (state == READ3) third <= memDataRead;
        if (state == LDC_ADDR) ldcAddr <= {readA, readB};
    end

    // One byte for low nibble E/F and three for 4-7 or D
    always_comb begin
        case (state)
            FETCH1:   nextState = READ1;
            READ1:    nextState = (memDataRead[3:1] == 3'b111) ? EXECUTE : FETCH2;
            FETCH2:   nextState = READ2;
            READ2:    nextState = (instrL[3:2] == 2'b01 || instrL == 4'hD) ? FETCH3 : EXECUTE;
            FETCH3:   nextState = READ3;
            READ3:    nextState = EXECUTE;
            EXECUTE:  nextState = (opcode == 8'hD2) ? LDC_ADDR : FETCH1;
            LDC_ADDR: nextState = WRITE_MEM;
            default:  nextState = FETCH1;
        endcase
    end

    always_comb begin
        case (instrH[2:0])
            3'd0:    condLow = 1'b0;
            3'd1:    condLow = flags.s ^ flags.v;
            3'd2:    condLow = (flags.s ^ flags.v) | flags.z;
            3'd3:    condLow = flags.c | flags.z;
            3'd4:    condLow = flags.v;
            3'd5:    condLow = flags.s;
            3'd6:    condLow = flags.z;
            default: condLow = flags.c;
        endcase
    end
    assign takeBranch = condLow ^ instrH[3];

    always_comb begin
        pcCmd = PC_HOLD;
        jumpTarget = {8'h00, second};
        readAddrA = resolve(second);
        readAddrB = workReg(secondL);
        aluOp = ALU_LD;
        aluA = readA;
        aluB = readB;
        regWrite.addr = resolve(second);
        regWrite.data = aluResult;
        regWrite.enable = 1'b0;
        flagsWrite = 1'b0;
        flagsData = newFlags;
        case (state)
            FETCH1, FETCH2, FETCH3: pcCmd = PC_INC;
            LDC_ADDR: begin
                readAddrA = workReg({secondL[3:1], 1'b0});
                readAddrB = workReg({secondL[3:1], 1'b1});
            end
            WRITE_MEM: readAddrA = workReg(secondH);
            EXECUTE: begin
                case (instrL)
                    4'h0: begin
                        if (instrH inside {4'h0, 4'h2, 4'h6, 4'hB}) begin
                            aluOp = aluOpT'({1'b0, instrH});
                            regWrite.enable = 1'b1;
                            flagsWrite = 1'b1;
                        end
                    end
                    4'h1: begin
                        // srp
                        regWrite.addr = RP_ADDR;
                        regWrite.data = second;
                        regWrite.enable = (instrH == 4'h3);
                    end
                    4'h2: begin
                        readAddrA = workReg(secondH);
                        regWrite.addr = workReg(secondH);
                        if (instrH inside {[4'h0:4'h5], 4'hA, 4'hB}) begin
                            aluOp = aluOpT'({1'b1, instrH});
                            regWrite.enable = (instrH != 4'hA);
                            flagsWrite = 1'b1;
                        end
                    end
                    4'h6: begin
                        aluB = third;
                        if (instrH == 4'hE) begin
                            aluA = third;
                            regWrite.enable = 1'b1;
                        end else if (instrH inside {[4'h0:4'h5], 4'hA, 4'hB}) begin
                            aluOp = aluOpT'({1'b1, instrH});
                            regWrite.enable = (instrH != 4'hA);
                            flagsWrite = 1'b1;
                        end
                    end
                    4'hA: begin
                        // djnz leaves the flags alone
                        readAddrA = workReg(instrH);
                        aluOp = ALU_DEC;
                        regWrite.addr = workReg(instrH);
                        regWrite.enable = 1'b1;
                        if (aluResult != 8'h00) pcCmd = PC_REL;
                    end
                    4'hB: if (takeBranch) pcCmd = PC_REL;
                    4'hC: begin
                        aluA = second;
                        regWrite.addr = workReg(instrH);
                        regWrite.enable = 1'b1;
                    end
                    4'hD: begin
                        jumpTarget = {second, third};
                        if (takeBranch) pcCmd = PC_ABS;
                    end
                    4'hE: begin
                        readAddrA = workReg(instrH);
                        aluOp = ALU_INC;
                        regWrite.addr = workReg(instrH);
                        regWrite.enable = 1'b1;
                        flagsWrite = 1'b1;
                    end
                    4'hF: begin
                        // rcf, scf, ccf
                        flagsData = flags;
                        flagsData.c = (instrH == 4'hE) ? ~flags.c : instrH[0];
                        flagsWrite = instrH inside {4'hC, 4'hD, 4'hE};
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign bus.addr = (state == WRITE_MEM) ? ldcAddr : pc;
    assign bus.dataWrite = readA;
    assign bus.write = (state == WRITE_MEM);
    assign bus.strobe = state inside {FETCH1, FETCH2, FETCH3, WRITE_MEM};

    // Only an ldc opcode reaches the memory write
    assert property (@(posedge clk) bus.write |-> bus.strobe && opcode == 8'hD2);
    assert property (@(posedge clk) disable iff (!rstN)
        state inside {FETCH1, READ1, FETCH2, READ2, FETCH3, READ3, EXECUTE, LDC_ADDR, WRITE_MEM});
endmodule

// File: source/z8Core.sv
`timescale 1ns/1ps

module z8Core
    import z8Pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic [7:0] memDataRead,
    output memBusT     bus
);
    logic [15:0] pc;
    logic [15:0] jumpTarget;
    pcCmdT       pcCmd;
    logic [7:0]  readAddrA;
    logic [7:0]  readAddrB;
    logic [7:0]  readA;
    logic [7:0]  readB;
    logic [3:0]  rp;
    flagsT       flags;
    flagsT       newFlags;
    flagsT       flagsData;
    logic        flagsWrite;
    regWriteT    regWrite;
    aluOpT       aluOp;
    logic [7:0]  aluA;
    logic [7:0]  aluB;
    logic [7:0]  aluResult;

    controlFsm sequencer (
        .clk(clk), .rstN(rstN), .memDataRead(memDataRead), .pc(pc),
        .readA(readA), .readB(readB), .flags(flags), .rp(rp),
        .aluResult(aluResult), .newFlags(newFlags), .bus(bus),
        .pcCmd(pcCmd), .jumpTarget(jumpTarget), .readAddrA(readAddrA),
        .readAddrB(readAddrB), .aluOp(aluOp), .aluA(aluA), .aluB(aluB),
        .regWrite(regWrite), .flagsWrite(flagsWrite), .flagsData(flagsData)
    );

    programCounter pcUnit (
        .clk(clk), .rstN(rstN), .pcCmd(pcCmd), .jumpTarget(jumpTarget), .pc(pc)
    );

    registerFile regs (
        .clk(clk), .rstN(rstN), .readAddrA(readAddrA), .readAddrB(readAddrB),
        .regWrite(regWrite), .flagsWrite(flagsWrite), .flagsData(flagsData),
        .readA(readA), .readB(readB), .flags(flags), .rp(rp)
    );

    alu aluUnit (
        .aluOp(aluOp), .a(aluA), .b(aluB), .flagsIn(flags),
        .result(aluResult), .newFlags(newFlags)
    );
endmodule

// File: verif/programImage.svh
`ifndef PROGRAM_IMAGE_SVH
`define PROGRAM_IMAGE_SVH

// Final jr that loops on itself
localparam logic [15:0] HALT_ADDR = 16'h00C9;

// Loaded from RESET_PC upward
logic [7:0] programBytes [$] = '{
    8'h31, 8'h10, 8'h0C, 8'h80, 8'h1C, 8'h01, 8'h2C, 8'h5A, 8'hE6, 8'h13, 8'hA5,
    8'hD2, 8'h20, 8'hD2, 8'h30,
    // Bank 2 holds its own address pair
    8'hE6, 8'h20, 8'h80, 8'hE6, 8'h21, 8'h02, 8'h31, 8'h20, 8'h2C, 8'hC3, 8'hD2, 8'h20,
    8'h31, 8'h10, 8'hD2, 8'h20,
    // Two-operand ops, flags copied out through FC to address 0000
    8'h2C, 8'h7F, 8'h3C, 8'h01, 8'h02, 8'h23, 8'hD2, 8'h20, 8'h31, 8'hF0, 8'hD2, 8'hCE,
    8'h31, 8'h10, 8'h02, 8'h22, 8'h31, 8'hF0, 8'hD2, 8'hCE, 8'h31, 8'h10,
    8'h12, 8'h23, 8'hD2, 8'h20, 8'h22, 8'h23, 8'h22, 8'h23, 8'h22, 8'h23, 8'hD2, 8'h20,
    8'h31, 8'hF0, 8'hD2, 8'hCE, 8'h31, 8'h10, 8'h32, 8'h23, 8'hD2, 8'h20,
    8'h4C, 8'h0F, 8'h42, 8'h24, 8'hD2, 8'h20, 8'h52, 8'h24, 8'hD2, 8'h20,
    8'hB2, 8'h24, 8'hD2, 8'h20, 8'h31, 8'hF0, 8'hD2, 8'hCE, 8'h31, 8'h10,
    8'hA2, 8'h23, 8'hD2, 8'h20, 8'h31, 8'hF0, 8'hD2, 8'hCE, 8'h31, 8'h10,
    8'h06, 8'h12, 8'h05, 8'hD2, 8'h20,
    // dec, inc, com, clr, inc r, then the carry ops
    8'h00, 8'h12, 8'h20, 8'hE2, 8'h60, 8'h12, 8'hD2, 8'h20, 8'hB0, 8'h12, 8'hD2, 8'h20,
    8'h2E, 8'hD2, 8'h20, 8'hDF, 8'hEF, 8'hEF, 8'hFF, 8'h31, 8'hF0, 8'hD2, 8'hCE,
    8'hCF, 8'hD2, 8'hCE, 8'h31, 8'h10,
    // Jumps around r5 markers
    8'h5C, 8'h11, 8'h6B, 8'h02, 8'hD2, 8'h50, 8'h5C, 8'h22, 8'hEB, 8'h02, 8'hD2, 8'h50,
    8'h5C, 8'h33, 8'hDF, 8'h7D, 8'h00, 8'hAB, 8'hD2, 8'h50, 8'hFF,
    8'hFD, 8'h00, 8'hB1, 8'hD2, 8'h50, 8'hFF, 8'h8B, 8'h02, 8'hD2, 8'h50,
    8'h0B, 8'h02, 8'h5C, 8'h44, 8'hD2, 8'h50, 8'h9B, 8'h02, 8'hD2, 8'h50, 8'h5C, 8'h55,
    8'hD2, 8'h50,
    // djnz loop, then halt
    8'h6C, 8'h05, 8'hD2, 8'h60, 8'h6A, 8'hFC, 8'h8B, 8'hFE
};

logic [15:0] expAddr [$] = '{
    16'h8001, 16'h8001, 16'h8002, 16'h8001, 16'h8001, 16'h0000, 16'h0000, 16'h8001,
    16'h8001, 16'h0000, 16'h8001, 16'h8001, 16'h8001, 16'h8001, 16'h0000, 16'h8001,
    16'h0000, 16'h8001, 16'h8001, 16'h8001, 16'h8001, 16'h0000, 16'h0000, 16'h8001,
    16'h8001, 16'h8001, 16'h8001, 16'h8001, 16'h8001, 16'h8001, 16'h8001, 16'h8001
};

// Flags byte is c z s v in bits 7 to 4
logic [7:0] expData [$] = '{
    8'h5A, 8'hA5, 8'hC3, 8'h5A, 8'h80, 8'h30, 8'hD0, 8'h02,
    8'hFF, 8'hA0, 8'hFD, 8'hFF, 8'h0F, 8'h00, 8'h40, 8'h00,
    8'hA0, 8'h05, 8'hFA, 8'h00, 8'h01, 8'h80, 8'h00, 8'h11,
    8'h33, 8'h44, 8'h55, 8'h05, 8'h04, 8'h03, 8'h02, 8'h01
};

function automatic string testName(input int idx);
    if (idx < 4) return "loads";
    if (idx < 7) return "add";
    if (idx < 8) return "adc";
    if (idx < 10) return "sub";
    if (idx < 11) return "sbc";
    if (idx < 12) return "or";
    if (idx < 13) return "and";
    if (idx < 15) return "xor";
    if (idx < 17) return "cp";
    if (idx < 18) return "add immediate";
    if (idx < 21) return "one-operand";
    if (idx < 23) return "carry ops";
    if (idx < 27) return "jumps";
    return "djnz";
endfunction

`endif

// File: verif/z8CoreTb.sv
`timescale 1ns/1ps

module z8CoreTb
    import z8Pkg::*;
();
    // About 100 instructions of at most 7 cycles plus a wide margin
    localparam int CYCLE_LIMIT = 2000;

    logic        clk = 1'b0;
    logic        rstN;
    logic [7:0]  memDataRead;
    memBusT      bus;

    logic [7:0]  mem [65536];
    logic        readPending = 1'b0;
    logic [15:0] readAddr = 16'h0000;
    logic        fetchSeen = 1'b0;
    int          writeIdx = 0;
    int          cycles = 0;

    `include "programImage.svh"

    z8Core DUT (
        .clk(clk),
        .rstN(rstN),
        .memDataRead(memDataRead),
        .bus(bus)
    );

    always #50 clk = ~clk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic checkWrite(input logic [15:0] addr, input logic [7:0] data);
        assert (fetchSeen)
            else failRun("memory write happened before the first fetch");
        assert (writeIdx < expAddr.size())
            else failRun("more memory writes than expected");
        assert (addr == expAddr[writeIdx] && data == expData[writeIdx])
            else failRun($sformatf("ERROR test %s write %0d: expected %h <= %h, actual %h <= %h",
                testName(writeIdx), writeIdx, expAddr[writeIdx], expData[writeIdx],
                addr, data));
    endtask

    task automatic finishRun;
        if (writeIdx == expAddr.size()) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            failRun($sformatf("halt loop reached after %0d of %0d expected writes",
                writeIdx, expAddr.size()));
        end
    endtask

    initial begin
        rstN = 1'b0;
        memDataRead = 8'h00;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5C;
        end
        foreach (programBytes[i]) begin
            mem[int'(RESET_PC) + i] = programBytes[i];
        end
        repeat (4) @(negedge clk);
        rstN = 1'b1;
    end

    // Memory answers one cycle after the strobe
    always @(negedge clk) begin
        if (readPending) begin
            memDataRead <= mem[readAddr];
        end
        readPending <= bus.strobe && !bus.write;
        readAddr <= bus.addr;
        if (bus.strobe && bus.write) begin
            mem[bus.addr] <= bus.dataWrite;
            checkWrite(bus.addr, bus.dataWrite);
            writeIdx = writeIdx + 1;
        end
        if (rstN && bus.strobe && !bus.write && bus.addr == HALT_ADDR) begin
            finishRun();
        end
    end

    // The first fetch is the strobe seen at a rising edge out of reset
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rstN && bus.strobe && !bus.write && bus.addr == RESET_PC) begin
            fetchSeen <= 1'b1;
        end
        if (cycles >= CYCLE_LIMIT) begin
            failRun("timeout, the program never reached the halt loop");
        end
    end

    assert property (@(posedge clk) $rose(rstN) |-> bus.strobe && bus.addr == RESET_PC)
        else failRun("first fetch after reset is not at the reset address");

    assert property (@(posedge clk) !rstN |-> !bus.write)
        else failRun("memory write during reset");
endmodule

// File: project.f
+incdir+verif
source/z8Pkg.sv
source/alu.sv
source/registerFile.sv
source/programCounter.sv
source/controlFsm.sv
source/z8Core.sv
verif/z8CoreTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module z8CoreTb -f project.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run passed" ||
{ echo "run failed"; exit 1; }
